// File: compile.f
src/cpu_pkg.sv
src/stage_dest_if.sv
src/pipeline_control.sv
src/fetch_stage.sv
src/decode_datapath.sv
src/execute_stage.sv
src/memory_writeback.sv
src/cpu.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

// File: tb/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

    localparam int TIMEOUT_CYCLES = 1000;
    localparam int TEST_COUNT     = 5;

    logic           clk;
    logic           reset_n;
    cpu_pkg::word_t i_addr;
    cpu_pkg::word_t i_data;
    logic           d_read;
    logic           d_write;
    cpu_pkg::word_t d_addr;
    cpu_pkg::word_t d_wdata;
    cpu_pkg::word_t d_rdata;
    cpu_pkg::word_t output_port;
    cpu_pkg::word_t num_inst;
    logic           is_halted;

    cpu_pkg::word_t imem [256];
    cpu_pkg::word_t dmem [256];
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t expected [$];
    cpu_pkg::word_t seen [$];       // output_port history of the current run
    cpu_pkg::word_t last_out;
    int             errors;
    int             cycles;
    int             data_reads;     // Cycles with d_read high

    cpu #(.RESET_PC(16'h0000)) cpu_inst (
        .clk(clk), .reset_n(reset_n), .i_addr(i_addr), .i_data(i_data),
        .d_read(d_read), .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_rdata(d_rdata), .output_port(output_port), .num_inst(num_inst),
        .is_halted(is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Memories

    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[7:0]];

    always @(posedge clk) begin
        if (d_write) dmem[d_addr[7:0]] <= d_wdata;
        if (d_read) data_reads++;
    end

    always @(negedge clk) begin
        if (reset_n) begin
            last_out = '0;
        end else if (output_port !== last_out) begin
            seen.push_back(output_port);
            last_out = output_port;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // Helpers

    function automatic cpu_pkg::word_t i_format(input cpu_pkg::opcode_t op,
        input cpu_pkg::reg_idx_t rs, input cpu_pkg::reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_pkg::word_t r_format(input cpu_pkg::reg_idx_t rs,
        input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t rd, input cpu_pkg::funct_t fn);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, fn};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic expect_wwd(input cpu_pkg::reg_idx_t rs, input cpu_pkg::word_t value);
        prog.push_back(r_format(rs, 2'd0, 2'd0, cpu_pkg::FN_WWD));
        expected.push_back(value);
    endtask

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            imem[a] = {cpu_pkg::OP_JMP, 4'h0, 8'(a)};  // Unused words jump to themselves
        end
        foreach (prog[i]) imem[i] = prog[i];
    endtask

    task automatic fill_data();
        for (int a = 0; a < 256; a++) begin
            dmem[a] = {8'(a), ~8'(a)};
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b1;
        seen.delete();
        repeat (8) @(negedge clk);
        reset_n = 1'b0;
    endtask

    task automatic run_program(input int exp_count);
        cpu_pkg::word_t count_at_halt;
        cpu_pkg::word_t out_at_halt;
        apply_reset();
        while (is_halted !== 1'b1) @(negedge clk);
        count_at_halt = num_inst;
        out_at_halt   = output_port;
        if (num_inst !== cpu_pkg::word_t'(exp_count))
            report_error($sformatf("num_inst is %0d, expected %0d", num_inst, exp_count));
        repeat (10) @(negedge clk);
        if (num_inst !== count_at_halt)
            report_error($sformatf("num_inst moved to %0d after halt", num_inst));
        if (output_port !== out_at_halt)
            report_error($sformatf("output_port moved to %h after halt", output_port));
    endtask

    task automatic compare_outputs();
        if (seen.size() != expected.size())
            report_error($sformatf("%0d output_port values seen, expected %0d",
                                   seen.size(), expected.size()));
        foreach (expected[i]) begin
            if (i < seen.size() && seen[i] !== expected[i])
                report_error($sformatf("output_port value %0d is %h, expected %h",
                                       i, seen[i], expected[i]));
        end
    endtask

    task automatic check_idle(input string when);
        if (is_halted !== 1'b0) report_error($sformatf("is_halted is %b %s", is_halted, when));
        if (d_read !== 1'b0) report_error($sformatf("d_read is %b %s", d_read, when));
        if (d_write !== 1'b0) report_error($sformatf("d_write is %b %s", d_write, when));
        if (num_inst !== 16'h0000) report_error($sformatf("num_inst is %h %s", num_inst, when));
        if (output_port !== 16'h0000)
            report_error($sformatf("output_port is %h %s", output_port, when));
    endtask

    ////////////////////
    // Directed tests

    task automatic check_reset();
        prog.delete();
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        load_program();
        @(negedge clk);
        reset_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_idle("while reset is held");
        end
        reset_n = 1'b0;
        @(negedge clk);
        check_idle("in the first cycle after reset");
    endtask

    task automatic arith_chain();
        cpu_pkg::word_t r [4];
        prog.delete();
        expected.delete();
        r = '{default: '0};
        r[1] = r[0] + 16'h0027;
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h27));
        expect_wwd(2'd1, r[1]);
        r[2] = {8'hA5, 8'h00};
        prog.push_back(i_format(cpu_pkg::OP_LHI, 2'd0, 2'd2, 8'hA5));
        expect_wwd(2'd2, r[2]);
        r[3] = r[1] + r[2];
        prog.push_back(r_format(2'd1, 2'd2, 2'd3, cpu_pkg::FN_ADD));
        expect_wwd(2'd3, r[3]);
        r[0] = r[1] - r[3];
        prog.push_back(r_format(2'd1, 2'd3, 2'd0, cpu_pkg::FN_SUB));
        expect_wwd(2'd0, r[0]);
        r[1] = r[0] & r[3];
        prog.push_back(r_format(2'd0, 2'd3, 2'd1, cpu_pkg::FN_AND));
        expect_wwd(2'd1, r[1]);
        r[2] = r[1] | r[0];
        prog.push_back(r_format(2'd1, 2'd0, 2'd2, cpu_pkg::FN_ORR));
        expect_wwd(2'd2, r[2]);
        r[3] = r[2] + 16'hFFF0;     // Negative immediate
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd2, 2'd3, 8'hF0));
        expect_wwd(2'd3, r[3]);
        r[0] = r[3] | 16'h008F;     // ORI zero-extends
        prog.push_back(i_format(cpu_pkg::OP_ORI, 2'd3, 2'd0, 8'h8F));
        expect_wwd(2'd0, r[0]);
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        load_program();
        run_program(prog.size());
        compare_outputs();
    endtask

    task automatic memory_roundtrip();
        cpu_pkg::word_t words [3];
        prog.delete();
        expected.delete();
        fill_data();
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h40));    // Base address
        for (int i = 0; i < 3; i++) begin
            words[i] = cpu_pkg::word_t'($urandom);
            words[i][3:0] = 4'(i + 1);     // Distinct and nonzero
            prog.push_back(i_format(cpu_pkg::OP_LHI, 2'd0, 2'd1, words[i][15:8]));
            prog.push_back(i_format(cpu_pkg::OP_ORI, 2'd1, 2'd1, words[i][7:0]));
            prog.push_back(i_format(cpu_pkg::OP_SWD, 2'd3, 2'd1, 8'(i)));
        end
        for (int i = 0; i < 3; i++) begin
            prog.push_back(i_format(cpu_pkg::OP_LWD, 2'd3, 2'd2, 8'(i)));
            expect_wwd(2'd2, words[i]);    // Load-use
        end
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        load_program();
        data_reads = 0;
        run_program(prog.size());
        compare_outputs();
        if (data_reads != 3)
            report_error($sformatf("d_read was high in %0d cycles, expected 3", data_reads));
        for (int i = 0; i < 3; i++) begin
            if (dmem[8'h40 + i] !== words[i])
                report_error($sformatf("data word %0d is %h, expected %h",
                                       8'h40 + i, dmem[8'h40 + i], words[i]));
        end
    endtask

    task automatic branch_and_jump();
        prog.delete();
        expected.delete();
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h07));
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h07));
        prog.push_back(i_format(cpu_pkg::OP_BEQ, 2'd1, 2'd2, 8'd2));     // Taken to 5
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h61));
        prog.push_back(r_format(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD));
        prog.push_back(i_format(cpu_pkg::OP_BNE, 2'd1, 2'd2, 8'd2));     // Falls through
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h11));
        expect_wwd(2'd3, 16'h0011);
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h09));
        prog.push_back(i_format(cpu_pkg::OP_BEQ, 2'd1, 2'd2, 8'd2));     // Falls through
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h22));
        expect_wwd(2'd3, 16'h0022);
        prog.push_back(i_format(cpu_pkg::OP_BNE, 2'd1, 2'd2, 8'd2));     // Taken to 15
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h62));
        prog.push_back(r_format(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD));
        prog.push_back({cpu_pkg::OP_JMP, 12'd19});
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h63));
        prog.push_back(r_format(2'd3, 2'd0, 2'd0, cpu_pkg::FN_WWD));
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd3, 8'h33));    // Jump target
        expect_wwd(2'd3, 16'h0033);
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        load_program();
        run_program(15);
        compare_outputs();
        foreach (seen[i]) begin
            if (seen[i] inside {16'h0061, 16'h0062, 16'h0063})
                report_error($sformatf("skipped marker %h reached output_port", seen[i]));
        end
    endtask

    task automatic halt_and_count();
        prog.delete();
        expected.delete();
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h44));
        expect_wwd(2'd1, 16'h0044);
        prog.push_back(r_format(2'd0, 2'd0, 2'd0, cpu_pkg::FN_HLT));
        prog.push_back(i_format(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h55));   // Must never run
        prog.push_back(r_format(2'd1, 2'd0, 2'd0, cpu_pkg::FN_WWD));
        load_program();
        run_program(3);
        compare_outputs();
    endtask

    initial begin
        void'($urandom(2234));
        reset_n = 1'b1;
        fill_data();
        check_reset();
        arith_chain();
        memory_roundtrip();
        branch_and_jump();
        halt_and_count();
        $display("Tests run: %0d, errors: %0d", TEST_COUNT, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb/cpu_sva.sv
`timescale 1ns/10ps

module cpu_sva (
    input logic           clk,
    input logic           reset_n,
    input logic           d_read,
    input logic           d_write,
    input logic           is_halted,
    input cpu_pkg::word_t num_inst
);

    // Data port does one thing per cycle
    assert property (@(posedge clk) disable iff (reset_n) !(d_read && d_write))
        else $error("d_read and d_write are high in the same cycle");

    assert property (@(posedge clk) (!reset_n && is_halted) |=> is_halted)
        else $error("is_halted fell while reset was not asserted");

    assert property (@(posedge clk) !reset_n |=> num_inst >= $past(num_inst))
        else $error("num_inst decreased while reset was not asserted");

    assert property (@(posedge clk) reset_n |=> !d_read && !d_write && !is_halted)
        else $error("d_read, d_write or is_halted is high right after reset");

endmodule

bind cpu cpu_sva sva_inst (
    .clk(clk), .reset_n(reset_n), .d_read(d_read), .d_write(d_write),
    .is_halted(is_halted), .num_inst(num_inst)
);

// File: src/cpu.sv
`timescale 1ns/10ps

module cpu #(
    parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
    input  logic           clk,
    input  logic           reset_n,
    output cpu_pkg::word_t i_addr,
    input  cpu_pkg::word_t i_data,
    output logic           d_read,
    output logic           d_write,
    output cpu_pkg::word_t d_addr,
    output cpu_pkg::word_t d_wdata,
    input  cpu_pkg::word_t d_rdata,
    output cpu_pkg::word_t output_port,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);

    cpu_pkg::word_t    if_id_inst;
    cpu_pkg::ctrl_t    id_ctrl;
    cpu_pkg::fwd_sel_t fwd_a;
    cpu_pkg::fwd_sel_t fwd_b;
    logic              stall;
    logic              take_branch;
    logic              take_jump;
    logic              halt_fetch;
    logic              operands_equal;

    cpu_pkg::word_t    op_a;
    cpu_pkg::word_t    op_b;
    cpu_pkg::word_t    imm_ext;
    cpu_pkg::word_t    ex_result;

    cpu_pkg::ctrl_t    ex_mem_ctrl;
    cpu_pkg::word_t    ex_mem_result;
    cpu_pkg::word_t    ex_mem_store_data;
    cpu_pkg::word_t    ex_mem_wwd_value;
    cpu_pkg::word_t    mem_result;

    logic              wb_write;
    cpu_pkg::reg_idx_t wb_dest;
    cpu_pkg::word_t    wb_data;

    stage_dest_if dest_bus ();

    pipeline_control control_inst (
        .clk(clk), .reset_n(reset_n), .if_id_inst(if_id_inst),
        .operands_equal(operands_equal), .dest(dest_bus.ctrl), .id_ctrl(id_ctrl),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .take_branch(take_branch),
        .take_jump(take_jump), .halt_fetch(halt_fetch)
    );

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_inst (
        .clk(clk), .reset_n(reset_n), .i_data(i_data), .stall(stall),
        .take_branch(take_branch), .take_jump(take_jump), .halt_fetch(halt_fetch),
        .i_addr(i_addr), .if_id_inst(if_id_inst)
    );

    decode_datapath decode_inst (
        .clk(clk), .reset_n(reset_n), .if_id_inst(if_id_inst), .fwd_a(fwd_a),
        .fwd_b(fwd_b), .ex_result(ex_result), .mem_result(mem_result),
        .wb_write(wb_write), .wb_dest(wb_dest), .wb_data(wb_data), .op_a(op_a),
        .op_b(op_b), .imm_ext(imm_ext), .operands_equal(operands_equal)
    );

    execute_stage execute_inst (
        .clk(clk), .reset_n(reset_n), .stall(stall), .id_ctrl(id_ctrl), .op_a(op_a),
        .op_b(op_b), .imm_ext(imm_ext), .ex_result(ex_result), .dest(dest_bus.ex),
        .ex_mem_ctrl(ex_mem_ctrl), .ex_mem_result(ex_mem_result),
        .ex_mem_store_data(ex_mem_store_data), .ex_mem_wwd_value(ex_mem_wwd_value)
    );

    memory_writeback mem_wb_inst (
        .clk(clk), .reset_n(reset_n), .ex_mem_ctrl(ex_mem_ctrl),
        .ex_mem_result(ex_mem_result), .ex_mem_store_data(ex_mem_store_data),
        .ex_mem_wwd_value(ex_mem_wwd_value), .d_rdata(d_rdata), .d_read(d_read),
        .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata), .dest(dest_bus.mem),
        .mem_result(mem_result), .wb_write(wb_write), .wb_dest(wb_dest),
        .wb_data(wb_data), .output_port(output_port), .num_inst(num_inst),
        .is_halted(is_halted)
    );

endmodule

// File: src/memory_writeback.sv
`timescale 1ns/10ps

module memory_writeback (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::ctrl_t    ex_mem_ctrl,
    input  cpu_pkg::word_t    ex_mem_result,
    input  cpu_pkg::word_t    ex_mem_store_data,
    input  cpu_pkg::word_t    ex_mem_wwd_value,
    input  cpu_pkg::word_t    d_rdata,
    output logic              d_read,
    output logic              d_write,
    output cpu_pkg::word_t    d_addr,
    output cpu_pkg::word_t    d_wdata,
    stage_dest_if.mem         dest,
    output cpu_pkg::word_t    mem_result,
    output logic              wb_write,
    output cpu_pkg::reg_idx_t wb_dest,
    output cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    output_port,
    output cpu_pkg::word_t    num_inst,
    output logic              is_halted
);

    // Data port straight from EX/MEM
    assign d_read  = ex_mem_ctrl.mem_read;
    assign d_write = ex_mem_ctrl.mem_write;
    assign d_addr  = ex_mem_result;
    assign d_wdata = ex_mem_store_data;

    assign mem_result = ex_mem_ctrl.mem_read ? d_rdata : ex_mem_result;

    assign dest.mem_reg_write = ex_mem_ctrl.reg_write;
    assign dest.mem_dest      = ex_mem_ctrl.dest;

    ////////////////////
    // MEM/WB and retire

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_write    <= 1'b0;
            output_port <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else begin
            wb_write <= ex_mem_ctrl.reg_write;
            if (ex_mem_ctrl.valid) num_inst <= num_inst + 16'd1;
            if (ex_mem_ctrl.wwd) output_port <= ex_mem_wwd_value;
            if (ex_mem_ctrl.halt) is_halted <= 1'b1;    // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= ex_mem_ctrl.dest;
        wb_data <= mem_result;
    end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           stall,
    input  cpu_pkg::ctrl_t id_ctrl,
    input  cpu_pkg::word_t op_a,
    input  cpu_pkg::word_t op_b,
    input  cpu_pkg::word_t imm_ext,
    output cpu_pkg::word_t ex_result,
    stage_dest_if.ex       dest,
    output cpu_pkg::ctrl_t ex_mem_ctrl,
    output cpu_pkg::word_t ex_mem_result,
    output cpu_pkg::word_t ex_mem_store_data,
    output cpu_pkg::word_t ex_mem_wwd_value
);

    cpu_pkg::ctrl_t ctrl_q;
    cpu_pkg::word_t a_q;
    cpu_pkg::word_t b_q;
    cpu_pkg::word_t imm_q;
    cpu_pkg::word_t imm_operand;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_y;

    ////////////////////
    // ID/EX

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ctrl_q <= '0;
        end else if (stall) begin
            ctrl_q <= '0;       // Bubble
        end else begin
            ctrl_q <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        a_q   <= op_a;
        b_q   <= op_b;
        imm_q <= imm_ext;
    end

    ////////////////////
    // ALU

    assign imm_operand = (ctrl_q.alu_op == cpu_pkg::ALU_PASS_B) ? {imm_q[7:0], 8'h00} : imm_q;
    assign alu_b       = ctrl_q.alu_src_imm ? imm_operand : b_q;

    always_comb begin
        case (ctrl_q.alu_op)
            cpu_pkg::ALU_SUB:    alu_y = a_q - alu_b;
            cpu_pkg::ALU_AND:    alu_y = a_q & alu_b;
            cpu_pkg::ALU_OR:     alu_y = a_q | alu_b;
            cpu_pkg::ALU_PASS_B: alu_y = alu_b;
            default:             alu_y = a_q + alu_b;   // Also load/store address
        endcase
    end

    assign ex_result = alu_y;

    assign dest.ex_reg_write = ctrl_q.reg_write;
    assign dest.ex_dest      = ctrl_q.dest;
    assign dest.ex_is_load   = ctrl_q.mem_read;

    ////////////////////
    // EX/MEM

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem_ctrl <= '0;
        end else begin
            ex_mem_ctrl <= ctrl_q;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_result     <= alu_y;
        ex_mem_store_data <= b_q;   // rt of SWD
        ex_mem_wwd_value  <= a_q;   // rs of WWD
    end

endmodule

// File: src/decode_datapath.sv
`timescale 1ns/10ps

module decode_datapath (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::word_t    if_id_inst,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::word_t    ex_result,
    input  cpu_pkg::word_t    mem_result,
    input  logic              wb_write,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    op_a,
    output cpu_pkg::word_t    op_b,
    output cpu_pkg::word_t    imm_ext,
    output logic              operands_equal
);

    cpu_pkg::word_t    regs [4];
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::word_t    rf_a;
    cpu_pkg::word_t    rf_b;
    logic [7:0]        imm8;

    function automatic cpu_pkg::word_t pick_operand(
        input cpu_pkg::fwd_sel_t sel,
        input cpu_pkg::word_t    rf_value,
        input cpu_pkg::word_t    ex_value,
        input cpu_pkg::word_t    mem_value
    );
        case (sel)
            cpu_pkg::FWD_EX:  return ex_value;
            cpu_pkg::FWD_MEM: return mem_value;
            default:          return rf_value;
        endcase
    endfunction

    assign rs   = if_id_inst[cpu_pkg::RS_LSB +: 2];
    assign rt   = if_id_inst[cpu_pkg::RT_LSB +: 2];
    assign imm8 = if_id_inst[cpu_pkg::IMM8_LSB +: 8];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) regs[i] <= '0;
        end else if (wb_write) begin
            regs[wb_dest] <= wb_data;
        end
    end

    // Write-first, WB result visible in the same cycle
    assign rf_a = (wb_write && wb_dest == rs) ? wb_data : regs[rs];
    assign rf_b = (wb_write && wb_dest == rt) ? wb_data : regs[rt];

    assign op_a = pick_operand(fwd_a, rf_a, ex_result, mem_result);
    assign op_b = pick_operand(fwd_b, rf_b, ex_result, mem_result);

    // ORI zero-extends, everything else sign-extends
    assign imm_ext = (if_id_inst[cpu_pkg::OPCODE_LSB +: 4] == cpu_pkg::OP_ORI) ?
                     {8'h00, imm8} : {{8{imm8[7]}}, imm8};

    assign operands_equal = (op_a == op_b);

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
    input  logic           clk,
    input  logic           reset_n,
    input  cpu_pkg::word_t i_data,
    input  logic           stall,
    input  logic           take_branch,
    input  logic           take_jump,
    input  logic           halt_fetch,
    output cpu_pkg::word_t i_addr,
    output cpu_pkg::word_t if_id_inst
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t if_id_pc;
    cpu_pkg::word_t branch_target;
    cpu_pkg::word_t jump_target;
    logic [7:0]     imm8;

    assign imm8          = if_id_inst[cpu_pkg::IMM8_LSB +: 8];
    assign branch_target = if_id_pc + 16'd1 + {{8{imm8[7]}}, imm8};
    assign jump_target   = {if_id_pc[15:12], if_id_inst[cpu_pkg::TARGET12_LSB +: 12]};
    assign i_addr        = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc         <= RESET_PC;
            if_id_inst <= cpu_pkg::NOP_INST;
        end else if (!stall) begin
            if (take_jump) begin
                pc         <= jump_target;
                if_id_inst <= cpu_pkg::NOP_INST;    // Squash the fall-through fetch
            end else if (take_branch) begin
                pc         <= branch_target;
                if_id_inst <= cpu_pkg::NOP_INST;
            end else if (halt_fetch) begin
                if_id_inst <= cpu_pkg::NOP_INST;    // PC parks
            end else begin
                pc         <= pc + 16'd1;
                if_id_inst <= i_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

endmodule

// File: src/pipeline_control.sv
`timescale 1ns/10ps

module pipeline_control (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::word_t    if_id_inst,
    input  logic              operands_equal,
    stage_dest_if.ctrl        dest,
    output cpu_pkg::ctrl_t    id_ctrl,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b,
    output logic              stall,
    output logic              take_branch,
    output logic              take_jump,
    output logic              halt_fetch
);

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::funct_t   funct;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t rd;
    logic              uses_rs;
    logic              uses_rt;
    logic              is_branch;
    logic              is_jump;
    logic              halt_q;

    assign opcode = cpu_pkg::opcode_t'(if_id_inst[cpu_pkg::OPCODE_LSB +: 4]);
    assign funct  = cpu_pkg::funct_t'(if_id_inst[cpu_pkg::FUNCT_LSB +: 6]);
    assign rs     = if_id_inst[cpu_pkg::RS_LSB +: 2];
    assign rt     = if_id_inst[cpu_pkg::RT_LSB +: 2];
    assign rd     = if_id_inst[cpu_pkg::RD_LSB +: 2];

    ////////////////////
    // Decode

    always_comb begin
        id_ctrl   = '0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            cpu_pkg::OP_BNE, cpu_pkg::OP_BEQ: begin
                id_ctrl.valid = 1'b1;
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;
                is_branch     = 1'b1;
            end
            cpu_pkg::OP_ADI, cpu_pkg::OP_ORI, cpu_pkg::OP_LHI, cpu_pkg::OP_LWD: begin
                id_ctrl.valid       = 1'b1;
                id_ctrl.alu_src_imm = 1'b1;
                id_ctrl.reg_write   = 1'b1;
                id_ctrl.dest        = rt;
                id_ctrl.mem_read    = (opcode == cpu_pkg::OP_LWD);
                uses_rs             = (opcode != cpu_pkg::OP_LHI);
                if (opcode == cpu_pkg::OP_ORI) id_ctrl.alu_op = cpu_pkg::ALU_OR;
                if (opcode == cpu_pkg::OP_LHI) id_ctrl.alu_op = cpu_pkg::ALU_PASS_B;
            end
            cpu_pkg::OP_SWD: begin
                id_ctrl.valid       = 1'b1;
                id_ctrl.alu_src_imm = 1'b1;
                id_ctrl.mem_write   = 1'b1;
                uses_rs             = 1'b1;
                uses_rt             = 1'b1;     // Store data
            end
            cpu_pkg::OP_JMP: begin
                id_ctrl.valid = 1'b1;
                is_jump       = 1'b1;
            end
            cpu_pkg::OP_RTYPE: begin
                case (funct)
                    cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND, cpu_pkg::FN_ORR: begin
                        id_ctrl.valid     = 1'b1;
                        id_ctrl.reg_write = 1'b1;
                        id_ctrl.dest      = rd;
                        id_ctrl.alu_op    = cpu_pkg::alu_op_t'(funct[2:0]);
                        uses_rs           = 1'b1;
                        uses_rt           = 1'b1;
                    end
                    cpu_pkg::FN_WWD: begin
                        id_ctrl.valid = 1'b1;
                        id_ctrl.wwd   = 1'b1;
                        uses_rs       = 1'b1;
                    end
                    cpu_pkg::FN_HLT: begin
                        id_ctrl.valid = 1'b1;
                        id_ctrl.halt  = 1'b1;
                    end
                    default: ;  // NOP_INST lands here
                endcase
            end
            default: ;
        endcase
    end

    ////////////////////
    // Hazards and forwarding

    function automatic cpu_pkg::fwd_sel_t fwd_for(
        input cpu_pkg::reg_idx_t src,
        input logic              ex_w,
        input cpu_pkg::reg_idx_t ex_d,
        input logic              mem_w,
        input cpu_pkg::reg_idx_t mem_d
    );
        if (ex_w && ex_d == src) return cpu_pkg::FWD_EX;     // Youngest wins
        if (mem_w && mem_d == src) return cpu_pkg::FWD_MEM;
        return cpu_pkg::FWD_REG;
    endfunction

    assign fwd_a = fwd_for(rs, dest.ex_reg_write, dest.ex_dest, dest.mem_reg_write, dest.mem_dest);
    assign fwd_b = fwd_for(rt, dest.ex_reg_write, dest.ex_dest, dest.mem_reg_write, dest.mem_dest);

    // Load in EX feeding decode, its data exists only from MEM on
    assign stall = dest.ex_is_load && dest.ex_reg_write &&
                   ((uses_rs && dest.ex_dest == rs) || (uses_rt && dest.ex_dest == rt));

    assign take_branch = is_branch && !stall &&
                         ((opcode == cpu_pkg::OP_BEQ) ? operands_equal : !operands_equal);
    assign take_jump   = is_jump && !stall;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_q <= 1'b0;
        end else if (id_ctrl.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt_fetch = halt_q | id_ctrl.halt;  // Blocks the fetch right behind HLT

endmodule

// File: src/stage_dest_if.sv
`timescale 1ns/10ps

interface stage_dest_if;

    // Instruction in EX
    logic              ex_reg_write;
    cpu_pkg::reg_idx_t ex_dest;
    logic              ex_is_load;

    // Instruction in MEM
    logic              mem_reg_write;
    cpu_pkg::reg_idx_t mem_dest;

    modport ex (output ex_reg_write, output ex_dest, output ex_is_load);

    modport mem (output mem_reg_write, output mem_dest);

    modport ctrl (
        input ex_reg_write,
        input ex_dest,
        input ex_is_load,
        input mem_reg_write,
        input mem_dest
    );

endinterface

// File: src/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B      // LHI
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM
    } fwd_sel_t;

    typedef struct packed {
        logic     valid;    // Counts toward num_inst
        alu_op_t  alu_op;
        logic     alu_src_imm;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     wwd;
        logic     halt;
        reg_idx_t dest;
    } ctrl_t;

    // R-type with an unused function code, decodes to nothing
    localparam word_t NOP_INST = 16'hF03F;

    // Field positions (LSB of each field)
    localparam int OPCODE_LSB   = 12;
    localparam int RS_LSB       = 10;
    localparam int RT_LSB       = 8;
    localparam int RD_LSB       = 6;
    localparam int FUNCT_LSB    = 0;
    localparam int IMM8_LSB     = 0;
    localparam int TARGET12_LSB = 0;

endpackage
